/* hdl/threefish_pkg.sv */
`default_nettype none

package threefish_pkg;

	typedef logic [63:0] word_t;
	typedef logic [1023:0] block_t;
	typedef logic [127:0] tweak_t;
	typedef logic [3:0] word_idx_t;
	typedef logic [6:0] round_t;

	typedef enum logic [2:0] {
		IDLE,
		SUBKEY_GENERATE,
		INIT_PLAINTEXT,
		SUBKEY_ADD,
		SUBKEY_ADD_IR_WRITE,
		MIX,
		MIX_IR_WRITE,
		FINISH
	} ctrl_state_t;

	localparam int NUM_WORDS = 16;
	localparam int NUM_ROUNDS = 80;
	localparam int ROUNDS_PER_INJECTION = 4;

	localparam word_t KEY_PARITY_CONST = 64'h1BD11BDAA9FC1A22;

	// Indexed by round mod 8, then by word pair
	localparam logic [5:0] ROT_TABLE [8][8] = '{
		'{6'd24, 6'd13, 6'd8, 6'd47, 6'd8, 6'd17, 6'd22, 6'd37},
		'{6'd38, 6'd19, 6'd10, 6'd55, 6'd49, 6'd18, 6'd23, 6'd52},
		'{6'd33, 6'd4, 6'd51, 6'd13, 6'd34, 6'd41, 6'd59, 6'd17},
		'{6'd5, 6'd20, 6'd48, 6'd41, 6'd47, 6'd28, 6'd16, 6'd25},
		'{6'd41, 6'd9, 6'd37, 6'd31, 6'd12, 6'd47, 6'd44, 6'd30},
		'{6'd16, 6'd34, 6'd56, 6'd51, 6'd4, 6'd53, 6'd42, 6'd41},
		'{6'd31, 6'd44, 6'd47, 6'd46, 6'd19, 6'd42, 6'd44, 6'd25},
		'{6'd9, 6'd48, 6'd35, 6'd52, 6'd23, 6'd31, 6'd37, 6'd20}
	};

	// New word i takes old word PERM_TABLE[i]
	localparam logic [3:0] PERM_TABLE [16] = '{
		4'd0, 4'd9, 4'd2, 4'd13, 4'd6, 4'd11, 4'd4, 4'd15,
		4'd10, 4'd7, 4'd12, 4'd3, 4'd14, 4'd5, 4'd8, 4'd1
	};

endpackage

`default_nettype wire

/* hdl/threefish_control.sv */
`timescale 1ns/1ps
`default_nettype none

module threefish_control (
	input wire logic clk_i,
	input wire logic reset_i,
	input wire logic start_i,
	output threefish_pkg::word_idx_t word_idx_o,
	output threefish_pkg::round_t round_o,
	output logic key_load_o,
	output logic subkey_generate_o,
	output logic input_write_o,
	output logic plaintext_select_o,
	output logic output_write_o,
	output logic add_select_o,
	output logic busy_o,
	output logic done_o
);

	threefish_pkg::ctrl_state_t state_q, state_d;
	threefish_pkg::word_idx_t word_q;
	threefish_pkg::round_t round_q;
	logic word_last;
	logic pair_last;
	logic inject_due;
	logic rounds_done;

	assign word_last = (word_q == threefish_pkg::word_idx_t'(threefish_pkg::NUM_WORDS - 1));
	assign pair_last = (word_q == threefish_pkg::word_idx_t'(threefish_pkg::NUM_WORDS - 2));
	assign inject_due = ((round_q % threefish_pkg::ROUNDS_PER_INJECTION) == 0);
	assign rounds_done = (round_q >= threefish_pkg::round_t'(threefish_pkg::NUM_ROUNDS));

	always_comb begin
		state_d = state_q;
		case (state_q)
			threefish_pkg::IDLE: if (start_i) state_d = threefish_pkg::INIT_PLAINTEXT;
			threefish_pkg::INIT_PLAINTEXT: state_d = threefish_pkg::SUBKEY_GENERATE;
			threefish_pkg::SUBKEY_GENERATE: if (word_last) state_d = threefish_pkg::SUBKEY_ADD;
			threefish_pkg::SUBKEY_ADD: if (word_last) state_d = threefish_pkg::SUBKEY_ADD_IR_WRITE;
			threefish_pkg::SUBKEY_ADD_IR_WRITE:
				state_d = rounds_done ? threefish_pkg::FINISH : threefish_pkg::MIX;
			threefish_pkg::MIX: if (pair_last) state_d = threefish_pkg::MIX_IR_WRITE;
			threefish_pkg::MIX_IR_WRITE:
				state_d = inject_due ? threefish_pkg::SUBKEY_GENERATE : threefish_pkg::MIX;
			threefish_pkg::FINISH: state_d = threefish_pkg::IDLE;
			default: state_d = threefish_pkg::IDLE;
		endcase
	end

	always_comb begin
		key_load_o = 1'b0;
		subkey_generate_o = 1'b0;
		input_write_o = 1'b0;
		plaintext_select_o = 1'b0;
		output_write_o = 1'b0;
		add_select_o = 1'b0;
		case (state_q)
			threefish_pkg::IDLE: begin // Inputs are only valid in the start cycle
				key_load_o = start_i;
				input_write_o = start_i;
				plaintext_select_o = 1'b1;
			end
			threefish_pkg::SUBKEY_GENERATE: subkey_generate_o = 1'b1;
			threefish_pkg::SUBKEY_ADD: begin
				add_select_o = 1'b1;
				output_write_o = 1'b1;
			end
			threefish_pkg::SUBKEY_ADD_IR_WRITE: begin
				add_select_o = 1'b1; // Identity copy
				input_write_o = 1'b1;
			end
			threefish_pkg::MIX: output_write_o = 1'b1;
			threefish_pkg::MIX_IR_WRITE: input_write_o = 1'b1; // Permuted copy
			default: ;
		endcase
	end

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			state_q <= threefish_pkg::IDLE;
			word_q <= '0;
			round_q <= '0;
		end else begin
			state_q <= state_d;
			case (state_q)
				threefish_pkg::INIT_PLAINTEXT: begin // Fresh run
					word_q <= '0;
					round_q <= '0;
				end
				threefish_pkg::SUBKEY_GENERATE, threefish_pkg::SUBKEY_ADD:
					word_q <= word_last ? '0 : word_q + 4'd1;
				threefish_pkg::MIX: begin
					if (pair_last) begin
						word_q <= '0;
						round_q <= round_q + 7'd1;
					end else begin
						word_q <= word_q + 4'd2;
					end
				end
				default: ;
			endcase
		end
	end

	assign word_idx_o = word_q;
	assign round_o = round_q;
	assign busy_o = (state_q != threefish_pkg::IDLE);
	assign done_o = (state_q == threefish_pkg::FINISH);

	a_no_generate_during_write: assert property (@(posedge clk_i) disable iff (reset_i)
		!(subkey_generate_o && output_write_o));
	a_mix_pairs_even: assert property (@(posedge clk_i) disable iff (reset_i)
		(state_q == threefish_pkg::MIX) |-> !word_q[0]);
	a_done_single_cycle: assert property (@(posedge clk_i) disable iff (reset_i)
		done_o |=> !done_o);

endmodule

`default_nettype wire

/* hdl/key_schedule.sv */
`timescale 1ns/1ps
`default_nettype none

module key_schedule (
	input wire logic clk_i,
	input wire logic reset_i,
	input wire logic key_load_i,
	input wire logic subkey_generate_i,
	input wire threefish_pkg::block_t key_i,
	input wire threefish_pkg::tweak_t tweak_i,
	input wire threefish_pkg::word_idx_t word_idx_i,
	input wire threefish_pkg::round_t round_i,
	output threefish_pkg::word_t subkey_word_o
);

	threefish_pkg::word_t key_words [threefish_pkg::NUM_WORDS + 1];
	threefish_pkg::word_t tweak_words [3];
	threefish_pkg::word_t subkey_store [threefish_pkg::NUM_WORDS];
	threefish_pkg::word_t key_parity;
	threefish_pkg::word_t subkey_word;
	logic key_loaded;
	logic [4:0] inject; // Injection number s
	logic [5:0] key_sum;
	logic [4:0] key_sel;
	logic [1:0] tweak_sel_a;
	logic [1:0] tweak_sel_b;

	always_comb begin
		key_parity = threefish_pkg::KEY_PARITY_CONST;
		for (int i = 0; i < threefish_pkg::NUM_WORDS; i++) begin
			key_parity = key_parity ^ key_i[64*i +: 64];
		end
	end

	assign inject = 5'(round_i / threefish_pkg::ROUNDS_PER_INJECTION);
	assign key_sum = {1'b0, inject} + {2'b00, word_idx_i};
	assign key_sel = 5'(key_sum % (threefish_pkg::NUM_WORDS + 1));
	assign tweak_sel_a = 2'(inject % 5'd3);
	assign tweak_sel_b = 2'((inject + 5'd1) % 5'd3);

	// Tweak and injection number only touch the top three words
	always_comb begin
		subkey_word = key_words[key_sel];
		case (word_idx_i)
			4'd13: subkey_word = key_words[key_sel] + tweak_words[tweak_sel_a];
			4'd14: subkey_word = key_words[key_sel] + tweak_words[tweak_sel_b];
			4'd15: subkey_word = key_words[key_sel] + {59'd0, inject};
			default: ;
		endcase
	end

	always_ff @(posedge clk_i) begin
		if (key_load_i) begin
			for (int i = 0; i < threefish_pkg::NUM_WORDS; i++) begin
				key_words[i] <= key_i[64*i +: 64];
			end
			key_words[threefish_pkg::NUM_WORDS] <= key_parity;
			tweak_words[0] <= tweak_i[63:0];
			tweak_words[1] <= tweak_i[127:64];
			tweak_words[2] <= tweak_i[63:0] ^ tweak_i[127:64];
		end
		if (subkey_generate_i) subkey_store[word_idx_i] <= subkey_word;
	end

	always_ff @(posedge clk_i) begin
		if (reset_i) key_loaded <= 1'b0;
		else if (key_load_i) key_loaded <= 1'b1;
	end

	assign subkey_word_o = subkey_store[word_idx_i];

	a_key_before_subkey: assert property (@(posedge clk_i) disable iff (reset_i)
		subkey_generate_i |-> key_loaded);

endmodule

`default_nettype wire

/* hdl/state_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

module state_buffer (
	input wire logic clk_i,
	input wire logic reset_i,
	input wire logic input_write_i,
	input wire logic plaintext_select_i,
	input wire logic output_write_i,
	input wire logic add_select_i,
	input wire threefish_pkg::block_t plaintext_i,
	input wire threefish_pkg::word_idx_t word_idx_i,
	input wire threefish_pkg::word_t result0_i,
	input wire threefish_pkg::word_t result1_i,
	output threefish_pkg::word_t x0_o,
	output threefish_pkg::word_t x1_o,
	output threefish_pkg::block_t ciphertext_o
);

	threefish_pkg::word_t in_words [threefish_pkg::NUM_WORDS];
	threefish_pkg::word_t out_words [threefish_pkg::NUM_WORDS];
	threefish_pkg::word_idx_t word_idx_next;

	assign word_idx_next = word_idx_i + 4'd1;

	// Input register doubles as the ciphertext holder
	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			for (int i = 0; i < threefish_pkg::NUM_WORDS; i++) begin
				in_words[i] <= '0;
			end
		end else if (input_write_i) begin
			for (int i = 0; i < threefish_pkg::NUM_WORDS; i++) begin
				if (plaintext_select_i) in_words[i] <= plaintext_i[64*i +: 64];
				else if (add_select_i) in_words[i] <= out_words[i];
				else in_words[i] <= out_words[threefish_pkg::PERM_TABLE[i]];
			end
		end
	end

	always_ff @(posedge clk_i) begin
		if (output_write_i) begin
			out_words[word_idx_i] <= result0_i;
			if (!add_select_i) out_words[word_idx_next] <= result1_i; // Second MIX word
		end
	end

	assign x0_o = in_words[word_idx_i];
	assign x1_o = in_words[word_idx_next];

	always_comb begin
		for (int i = 0; i < threefish_pkg::NUM_WORDS; i++) begin
			ciphertext_o[64*i +: 64] = in_words[i];
		end
	end

endmodule

`default_nettype wire

/* hdl/mix_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module mix_unit (
	input wire logic add_select_i,
	input wire threefish_pkg::word_t x0_i,
	input wire threefish_pkg::word_t x1_i,
	input wire threefish_pkg::word_t subkey_i,
	input wire threefish_pkg::word_idx_t word_idx_i,
	input wire threefish_pkg::round_t round_i,
	output threefish_pkg::word_t result0_o,
	output threefish_pkg::word_t result1_o
);

	threefish_pkg::word_t operand;
	threefish_pkg::word_t sum;
	threefish_pkg::word_t rotated;
	logic [5:0] rot_amt;
	logic [127:0] rot_wide;

	// Shared adder for both modes
	assign operand = add_select_i ? subkey_i : x1_i;
	assign sum = x0_i + operand;

	assign rot_amt = threefish_pkg::ROT_TABLE[round_i[2:0]][word_idx_i[3:1]];
	assign rot_wide = {x1_i, x1_i} << rot_amt; // Upper half is the left rotation
	assign rotated = rot_wide[127:64];

	assign result0_o = sum;
	assign result1_o = rotated ^ sum; // Ignored in add mode

endmodule

`default_nettype wire

/* hdl/threefish_engine.sv */
`timescale 1ns/1ps
`default_nettype none

module threefish_engine (
	input wire logic clk_i,
	input wire logic reset_i,
	input wire logic start_i,
	input wire threefish_pkg::block_t key_i,
	input wire threefish_pkg::block_t plaintext_i,
	input wire threefish_pkg::tweak_t tweak_i,
	output threefish_pkg::block_t ciphertext_o,
	output logic busy_o,
	output logic done_o
);

	threefish_pkg::word_idx_t word_idx;
	threefish_pkg::round_t round;
	threefish_pkg::word_t subkey_word;
	threefish_pkg::word_t x0;
	threefish_pkg::word_t x1;
	threefish_pkg::word_t result0;
	threefish_pkg::word_t result1;
	logic key_load;
	logic subkey_generate;
	logic input_write;
	logic plaintext_select;
	logic output_write;
	logic add_select;

	threefish_control u_control (
		.clk_i(clk_i),
		.reset_i(reset_i),
		.start_i(start_i),
		.word_idx_o(word_idx),
		.round_o(round),
		.key_load_o(key_load),
		.subkey_generate_o(subkey_generate),
		.input_write_o(input_write),
		.plaintext_select_o(plaintext_select),
		.output_write_o(output_write),
		.add_select_o(add_select),
		.busy_o(busy_o),
		.done_o(done_o)
	);

	key_schedule u_key_schedule (
		.clk_i(clk_i),
		.reset_i(reset_i),
		.key_load_i(key_load),
		.subkey_generate_i(subkey_generate),
		.key_i(key_i),
		.tweak_i(tweak_i),
		.word_idx_i(word_idx),
		.round_i(round),
		.subkey_word_o(subkey_word)
	);

	state_buffer u_state_buffer (
		.clk_i(clk_i),
		.reset_i(reset_i),
		.input_write_i(input_write),
		.plaintext_select_i(plaintext_select),
		.output_write_i(output_write),
		.add_select_i(add_select),
		.plaintext_i(plaintext_i),
		.word_idx_i(word_idx),
		.result0_i(result0),
		.result1_i(result1),
		.x0_o(x0),
		.x1_o(x1),
		.ciphertext_o(ciphertext_o)
	);

	mix_unit u_mix_unit (
		.add_select_i(add_select),
		.x0_i(x0),
		.x1_i(x1),
		.subkey_i(subkey_word),
		.word_idx_i(word_idx),
		.round_i(round),
		.result0_o(result0),
		.result1_o(result1)
	);

endmodule

`default_nettype wire

/* bench/threefish_engine_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module threefish_engine_tb;

	localparam int NUM_RANDOM = 12;
	localparam int NUM_BLOCKS = NUM_RANDOM + 6; // Aborted run included
	localparam int TIMEOUT_CYCLES = 2000 * NUM_BLOCKS + 2500;
	localparam logic [63:0] PARITY_C240 = 64'h1BD11BDAA9FC1A22;
	localparam int ROT [8][8] = '{
		'{24, 13, 8, 47, 8, 17, 22, 37}, '{38, 19, 10, 55, 49, 18, 23, 52},
		'{33, 4, 51, 13, 34, 41, 59, 17}, '{5, 20, 48, 41, 47, 28, 16, 25},
		'{41, 9, 37, 31, 12, 47, 44, 30}, '{16, 34, 56, 51, 4, 53, 42, 41},
		'{31, 44, 47, 46, 19, 42, 44, 25}, '{9, 48, 35, 52, 23, 31, 37, 20}
	};
	localparam int PERM [16] = '{0, 9, 2, 13, 6, 11, 4, 15, 10, 7, 12, 3, 14, 5, 8, 1};

	logic clk_i;
	logic reset_i;
	logic start_i;
	threefish_pkg::block_t key_i;
	threefish_pkg::block_t plaintext_i;
	threefish_pkg::tweak_t tweak_i;
	threefish_pkg::block_t ciphertext_o;
	logic busy_o;
	logic done_o;

	int errors = 0;
	int checks = 0;
	int cycle_count = 0;
	int done_count = 0;
	int blocks_done = 0;
	logic done_prev = 1'b0;

	threefish_engine dut_i (
		.clk_i(clk_i),
		.reset_i(reset_i),
		.start_i(start_i),
		.key_i(key_i),
		.plaintext_i(plaintext_i),
		.tweak_i(tweak_i),
		.ciphertext_o(ciphertext_o),
		.busy_o(busy_o),
		.done_o(done_o)
	);

	initial begin
		clk_i = 1'b0;
		forever #4 clk_i = ~clk_i;
	end

	always @(posedge clk_i) begin
		cycle_count++;
		if (cycle_count > TIMEOUT_CYCLES) begin
			$display("timeout after %0d cycles, the run did not complete", cycle_count);
			$display("tests failed");
			$finish;
		end
	end

	always @(negedge clk_i) begin
		if (done_prev) check_flag("done_o single cycle", 1'b0, done_o);
		if (done_o && !done_prev) done_count++;
		done_prev = done_o;
	end

	task automatic check_block(input string name, input threefish_pkg::block_t expected,
		input threefish_pkg::block_t actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("mismatch %s: expected %h actual %h", name, expected, actual);
		end
	endtask

	task automatic check_flag(input string name, input logic expected, input logic actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("mismatch %s: expected %b actual %b", name, expected, actual);
		end
	endtask

	function automatic threefish_pkg::word_t rotl(input threefish_pkg::word_t x, input int r);
		return (x << r) | (x >> (64 - r));
	endfunction

	function automatic threefish_pkg::block_t random_block();
		threefish_pkg::block_t b;
		for (int i = 0; i < 32; i++) b[32*i +: 32] = $urandom();
		return b;
	endfunction

	// Reference Threefish-1024 model with 80 rounds and 21 injections
	task automatic encrypt_model(input threefish_pkg::block_t key,
		input threefish_pkg::tweak_t tweak,
		input threefish_pkg::block_t pt, output threefish_pkg::block_t ct);
		threefish_pkg::word_t ks [17];
		threefish_pkg::word_t ts [3];
		threefish_pkg::word_t v [16];
		threefish_pkg::word_t f [16];
		int s;
		ks[16] = PARITY_C240;
		for (int i = 0; i < 16; i++) begin
			ks[i] = key[64*i +: 64];
			ks[16] = ks[16] ^ ks[i];
			v[i] = pt[64*i +: 64];
		end
		ts[0] = tweak[63:0];
		ts[1] = tweak[127:64];
		ts[2] = ts[0] ^ ts[1];
		for (int d = 0; d <= 80; d++) begin
			if (d % 4 == 0) begin
				s = d / 4;
				for (int i = 0; i < 16; i++) v[i] = v[i] + ks[(s + i) % 17];
				v[13] = v[13] + ts[s % 3];
				v[14] = v[14] + ts[(s + 1) % 3];
				v[15] = v[15] + 64'(s);
			end
			if (d < 80) begin
				for (int j = 0; j < 8; j++) begin
					f[2*j] = v[2*j] + v[2*j+1];
					f[2*j+1] = rotl(v[2*j+1], ROT[d % 8][j]) ^ f[2*j];
				end
				for (int i = 0; i < 16; i++) v[i] = f[PERM[i]];
			end
		end
		for (int i = 0; i < 16; i++) ct[64*i +: 64] = v[i];
	endtask

	task automatic pulse_start(input threefish_pkg::block_t k, input threefish_pkg::tweak_t t,
		input threefish_pkg::block_t p);
		@(posedge clk_i);
		start_i <= 1'b1;
		key_i <= k;
		tweak_i <= t;
		plaintext_i <= p;
		@(posedge clk_i);
		start_i <= 1'b0;
	endtask

	task automatic wait_done();
		while (!done_o) @(negedge clk_i);
	endtask

	task automatic run_block(input string name, input threefish_pkg::block_t k,
		input threefish_pkg::tweak_t t, input threefish_pkg::block_t p);
		threefish_pkg::block_t expected;
		encrypt_model(k, t, p, expected);
		pulse_start(k, t, p);
		@(negedge clk_i);
		check_flag({name, " busy"}, 1'b1, busy_o);
		wait_done();
		check_block(name, expected, ciphertext_o);
		blocks_done++;
	endtask

	initial begin
		threefish_pkg::block_t k;
		threefish_pkg::block_t p;
		threefish_pkg::block_t expected;
		threefish_pkg::tweak_t t;
		void'($urandom(32'h04fca913));
		reset_i = 1'b1;
		start_i = 1'b0;
		key_i = '0;
		tweak_i = '0;
		plaintext_i = '0;
		repeat (5) @(posedge clk_i);
		reset_i <= 1'b0;

		repeat (20) begin // Idle after reset
			@(negedge clk_i);
			check_flag("idle busy", 1'b0, busy_o);
			check_flag("idle done", 1'b0, done_o);
			check_block("idle ciphertext", '0, ciphertext_o);
		end

		run_block("zero block", '0, '0, '0);

		for (int n = 0; n < NUM_RANDOM; n++) begin
			repeat ($urandom_range(0, 4)) @(posedge clk_i);
			run_block($sformatf("random block %0d", n), random_block(),
				tweak_t_rand(), random_block());
		end

		// Start lands in the IDLE cycle right after done_o
		run_block("back to back a", random_block(), tweak_t_rand(), random_block());
		run_block("back to back b", random_block(), tweak_t_rand(), random_block());

		k = random_block();
		t = tweak_t_rand();
		p = random_block();
		encrypt_model(k, t, p, expected);
		pulse_start(k, t, p);
		repeat (100) @(posedge clk_i);
		pulse_start(random_block(), tweak_t_rand(), random_block()); // Must be ignored
		wait_done();
		check_block("start while busy", expected, ciphertext_o);
		blocks_done++;

		pulse_start(random_block(), tweak_t_rand(), random_block());
		repeat (300) @(posedge clk_i);
		reset_i <= 1'b1;
		repeat (5) @(posedge clk_i);
		reset_i <= 1'b0;
		repeat (1600) begin
			@(negedge clk_i);
			check_flag("after reset busy", 1'b0, busy_o);
			check_flag("after reset done", 1'b0, done_o);
		end
		run_block("after reset", random_block(), tweak_t_rand(), random_block());

		repeat (2) @(negedge clk_i);
		if (done_count != blocks_done) begin
			errors++;
			$display("done_o pulsed %0d times for %0d finished blocks", done_count, blocks_done);
		end
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0) $display("all tests passed");
		else $display("tests failed");
		$finish;
	end

	function automatic threefish_pkg::tweak_t tweak_t_rand();
		return {$urandom(), $urandom(), $urandom(), $urandom()};
	endfunction

endmodule

`default_nettype wire

/* verilog.f */
hdl/threefish_pkg.sv
hdl/threefish_control.sv
hdl/key_schedule.sv
hdl/state_buffer.sv
hdl/mix_unit.sv
hdl/threefish_engine.sv
bench/threefish_engine_tb.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing -j 0 --top-module threefish_engine_tb -f verilog.f -o sim_threefish
./obj_dir/sim_threefish > sim.log 2>&1 || true
cat sim.log
if grep -qx "all tests passed" sim.log; then
	exit 0
fi
exit 1
